//--- mini_core.f
+incdir+hdl
hdl/mini_core_pkg.sv
hdl/instr_decoder.sv
hdl/core_control.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/mini_core.sv
test/tb_clock.sv
test/mini_core_chk.sv
test/mini_core_tb.sv

//--- test/mini_core_tb.sv
`timescale 1ns/1ps

module mini_core_tb;
    import mini_core_pkg::*;

    localparam int NUM_WORDS = 60;
    localparam int LIMIT     = NUM_WORDS * 6 + 20;   // worst case six cycles a word

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_word_u instr;
    logic [1:0]  core_index;
    logic        busy;
    wb_t         wb;
    mem_req_t    mem_req;
    side_evt_t   evt;
    logic [3:0]  flags;

    logic [31:0] m_regs [8];   // shadow register file
    logic [3:0]  m_flags;      // {zero, overflow, sign, carry}
    wb_t         exp_wb  [7];
    mem_req_t    exp_mem [7];
    side_evt_t   exp_evt [7];
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          chk_fails;

    tb_clock tb_clock_i (.clk(clk));

    mini_core mini_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .core_index  (core_index),
        .busy        (busy),
        .wb          (wb),
        .mem_req     (mem_req),
        .evt         (evt),
        .flags       (flags)
    );

    bind mini_core mini_core_chk mini_core_chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .wb          (wb),
        .mem_req     (mem_req),
        .evt         (evt)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic cond_holds(input logic [3:0] cc, input logic [3:0] f);
        logic z;
        logic v;
        logic s;
        logic c;
        {z, v, s, c} = f;
        case (cc)
            4'd0:    return z;
            4'd1:    return ~z;
            4'd2:    return ~z & ~(s ^ v);
            4'd3:    return s ^ v;
            4'd4:    return ~(s ^ v);
            4'd5:    return z | (s ^ v);   // le
            4'd6:    return c;
            4'd7:    return ~c;
            4'd8:    return s;
            4'd9:    return ~s;
            4'd10:   return 1'b1;
            4'd11:   return 1'b0;
            4'd12:   return v;
            4'd13:   return ~v;
            4'd14:   return c & ~z;
            default: return ~c | ~z;
        endcase
    endfunction

    function automatic logic jump_taken(input logic [2:0] sel, input logic [3:0] f);
        case (sel)
            3'd1:    return cond_holds(4'd0, f);
            3'd2:    return cond_holds(4'd1, f);
            3'd3:    return cond_holds(4'd2, f);
            3'd4:    return cond_holds(4'd4, f);
            3'd5:    return cond_holds(4'd3, f);
            3'd6:    return cond_holds(4'd5, f);
            default: return 1'b1;
        endcase
    endfunction

    // returns {flags, result}
    function automatic logic [35:0] alu_model(input logic [3:0] opc, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [32:0] s;
        logic        v;
        logic        arith;
        s     = '0;
        v     = 1'b0;
        arith = (opc == 4'd0) || (opc == 4'd1) || (opc == 4'd12);
        case (opc)
            4'd0:        s = {1'b0, a} + {1'b0, b};
            4'd1, 4'd12: s = {1'b0, a} - {1'b0, b};
            4'd2:        s[31:0] = a & b;
            4'd3:        s[31:0] = a | b;
            4'd4:        s[31:0] = a ^ b;
            4'd5:        s[31:0] = a << b[4:0];
            4'd6:        s[31:0] = a >> b[4:0];
            default:     s = '0;
        endcase
        if (opc == 4'd0) v = (a[31] == b[31]) && (s[31] != a[31]);
        else if (arith)  v = (a[31] != b[31]) && (s[31] != a[31]);
        return {s[31:0] == '0, v, s[31], arith & s[32], s[31:0]};
    endfunction

    function automatic logic [31:0] enc_long(input logic movl, input logic [3:0] cc,
                                             input logic [2:0] rd, input logic [15:0] imm);
        return {1'b1, 5'd0, movl, cc, rd, 2'd0, imm};
    endfunction

    function automatic logic [15:0] enc_alu(input logic [3:0] opc, input logic [3:0] cc,
                                            input logic [2:0] rd, input logic [2:0] rs);
        return {2'b01, opc, cc, rd, rs};
    endfunction

    function automatic logic [15:0] enc_mem(input logic store, input logic [3:0] cc,
                                            input logic [2:0] rdata, input logic [2:0] raddr);
        return {5'b00000, store, cc, rdata, raddr};
    endfunction

    function automatic logic [15:0] enc_mov(input logic [3:0] cc, input logic [2:0] rd,
                                            input logic [2:0] rs);
        return {6'b000010, cc, rd, rs};
    endfunction

    function automatic logic [15:0] enc_jump(input logic [2:0] sel, input logic [2:0] rt);
        return {4'b0001, sel, rt, 6'd0};
    endfunction

    function automatic logic [15:0] enc_movf(input logic [2:0] rd);
        return {7'b0001000, rd, 6'd0};
    endfunction

    // coreidx, int and stack writes
    function automatic logic [15:0] enc_grp(input logic [4:0] code, input logic [3:0] cc,
                                            input logic [2:0] r);
        return {2'b00, code, cc, r, 2'd0};
    endfunction

    task automatic write_back(input int slot, input logic [2:0] idx, input logic [31:0] data);
        exp_wb[slot] = '{1'b1, idx, data};
        m_regs[idx]  = data;
    endtask

    task automatic model_short(input logic [15:0] h, input int slot);
        logic [35:0] fr;
        logic        ok;
        ok = cond_holds(h[9:6], m_flags);
        if (h[14]) begin
            fr = alu_model(h[13:10], m_regs[h[5:3]], m_regs[h[2:0]]);
            if (ok) begin
                m_flags = fr[35:32];
                if (h[13:10] != 4'b1100) write_back(slot, h[5:3], fr[31:0]);
            end
        end else if (h[13:11] == 3'b000) begin
            if (ok) exp_mem[slot] = '{1'b1, h[10], m_regs[h[2:0]], m_regs[h[5:3]]};
        end else if (h[13:10] == 4'b0010) begin
            if (ok) write_back(slot, h[5:3], m_regs[h[2:0]]);
        end else if (h[13:9] == 5'b01000) begin
            if (ok) write_back(slot, h[8:6], {28'd0, m_flags});
        end else if (h[13:12] == 2'b01) begin
            if (jump_taken(h[11:9], m_flags)) begin
                exp_evt[slot].jump        = 1'b1;
                exp_evt[slot].jump_target = m_regs[h[8:6]];
            end
        end else begin
            ok = cond_holds(h[8:5], m_flags);   // alternate condition field
            if (ok && h[13:9] == 5'b10000) begin
                write_back(slot, h[4:2], {30'd0, core_index});
            end else if (ok && h[13:9] == 5'b10001) begin
                exp_evt[slot].intr    = 1'b1;
                exp_evt[slot].int_num = h[4:2];
            end else if (ok && h[13:9] >= 5'b10010 && h[13:9] <= 5'b10101) begin
                exp_evt[slot].stack_we     = 1'b1;
                exp_evt[slot].stack_coding = h[10:9] - 2'd2;
                exp_evt[slot].stack_value  = m_regs[h[4:2]];
            end
        end
    endtask

    task automatic model_long(input logic [31:0] w);
        logic [31:0] r;
        r = m_regs[w[20:18]];
        if (w[25]) r[15:0] = w[15:0];
        else r[31:16] = w[15:0];
        if (cond_holds(w[24:21], m_flags)) write_back(2, w[20:18], r);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [79:0] expv, input logic [79:0] actv);
        checks++;
        assert (actv === expv) else begin
            errors++;
            $display("error %s %s expected %h actual %h", name, what, expv, actv);
        end
    endtask

    task automatic run_word(input string name, input logic [31:0] w);
        int len;
        for (int i = 0; i < 7; i++) begin
            exp_wb[i]  = '0;
            exp_mem[i] = '0;
            exp_evt[i] = '0;
        end
        len = w[31] ? 3 : 5;
        if (w[31]) begin
            model_long(w);
        end else begin
            model_short(w[31:16], 2);
            model_short(w[15:0], 4);   // sees the upper half's regs and flags
        end
        while (busy) @(negedge clk);
        instr       = w;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
        for (int c = 1; c <= len; c++) begin
            @(negedge clk);
            check_value(name, "wb", exp_wb[c], wb);
            check_value(name, "mem_req", exp_mem[c], mem_req);
            check_value(name, "evt", exp_evt[c], evt);
            check_value(name, "busy", c < len, busy);
        end
        check_value(name, "flags", m_flags, flags);
    endtask

    initial begin
        logic [31:0] w;
        seed        = 32'hc735_6110;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        core_index  = 2'd2;
        m_flags     = '0;
        for (int r = 0; r < 8; r++) m_regs[r] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset", "busy", 1'b0, busy);
        check_value("reset", "strobes", '0, {wb.valid, mem_req.valid, evt.jump, evt.intr,
                                            evt.stack_we});

        for (int r = 0; r < 8; r++) begin
            w = $random(seed);
            run_word("movl", enc_long(1'b1, 4'd10, r[2:0], w[15:0]));
            run_word("movh", enc_long(1'b0, 4'd10, r[2:0], w[31:16]));
        end

        for (int i = 0; i < 12; i++) begin
            w = $random(seed);
            run_word("alu", {enc_alu(w[3:0], 4'd10, w[6:4], w[9:7]),
                             enc_alu(w[13:10], w[17:14], w[20:18], w[23:21])});
        end

        // even codes compare two registers, odd codes compare one with itself
        for (int cc = 0; cc < 16; cc++) begin
            w = $random(seed);
            run_word("cond", {enc_alu(4'b1100, 4'd10, w[2:0], cc[0] ? w[2:0] : w[5:3]),
                              enc_mov(cc[3:0], w[8:6], w[11:9])});
        end
        w = $random(seed);
        run_word("long_nv", enc_long(1'b1, 4'd11, w[2:0], w[31:16]));
        run_word("long_cond", enc_long(1'b0, w[7:4], w[10:8], w[31:16]));

        for (int i = 0; i < 2; i++) begin
            w = $random(seed);
            run_word("mem", {enc_mem(1'b0, 4'd10, w[2:0], w[5:3]),
                             enc_mem(1'b1, 4'd10, w[8:6], w[11:9])});
        end

        for (int j = 1; j < 8; j++) begin
            w = $random(seed);
            run_word("jump", {enc_alu(4'b1100, 4'd10, w[2:0], w[5:3]),
                              enc_jump(j[2:0], w[8:6])});
        end

        w = $random(seed);
        run_word("int_coreidx", {enc_grp(5'b10001, 4'd10, w[2:0]),
                                 enc_grp(5'b10000, 4'd10, w[5:3])});
        run_word("stack", {enc_grp(5'b10010, 4'd10, w[8:6]),
                           enc_grp(5'b10011, 4'd10, w[11:9])});
        run_word("stack", {enc_grp(5'b10100, w[15:12], w[18:16]),
                           enc_grp(5'b10101, w[22:19], w[25:23])});
        // movf condition field overlaps its destination, c and nc cover both
        run_word("movf", {enc_movf(3'd6), enc_movf(3'd7)});

        chk_fails = mini_core_i.mini_core_chk_i.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/mini_core_chk.sv
`timescale 1ns/1ps

module mini_core_chk
    import mini_core_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        instr_valid,
    input instr_word_u instr,
    input logic        busy,
    input wb_t         wb,
    input mem_req_t    mem_req,
    input side_evt_t   evt
);

    int         fail_count = 0;
    logic       accept;
    logic [4:0] strobes;

    assign accept  = instr_valid && !busy;
    assign strobes = {wb.valid, mem_req.valid, evt.jump, evt.intr, evt.stack_we};

    // long word: busy for three cycles after the accept edge
    busy_long: assert property (@(posedge clk) disable iff (!rst_n)
        accept && instr.long_i.is_long |=> busy ##1 busy ##1 busy ##1 !busy)
        else begin
            fail_count++;
            $error("busy did not follow the long word timing");
        end

    busy_pair: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !instr.long_i.is_long
            |=> busy ##1 busy ##1 busy ##1 busy ##1 busy ##1 !busy)
        else begin
            fail_count++;
            $error("busy did not follow the short pair timing");
        end

    one_strobe: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(strobes))
        else begin
            fail_count++;
            $error("more than one strobe in the same cycle");
        end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> strobes == '0)
        else begin
            fail_count++;
            $error("strobe issued while reset is asserted");
        end

    // cycle after the upper half commit edge is the bubble
    quiet_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !instr.long_i.is_long
            |=> strobes == '0 ##1 strobes == '0 ##2 strobes == '0)
        else begin
            fail_count++;
            $error("strobe issued before the first commit or in the bubble cycle");
        end

    strobe_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        strobes != '0 |-> busy)
        else begin
            fail_count++;
            $error("strobe issued while the core is idle");
        end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

endmodule

//--- hdl/mini_core.sv
`timescale 1ns/1ps
`include "mini_core_config.svh"

module mini_core
    import mini_core_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  instr_word_u                instr,
    input  logic [`MC_CORE_NUMBER-1:0] core_index,
    output logic                       busy,
    output wb_t                        wb,
    output mem_req_t                   mem_req,
    output side_evt_t                  evt,
    output logic [`MC_FLAGS-1:0]       flags
);

    logic                 dec_en;
    logic                 half_sel;
    instr_word_u          word;      // accepted instruction word
    decoded_op_t          op;
    logic                 rf_we;
    logic                 flags_we;
    logic [`MC_WIDTH-1:0] result;
    logic [`MC_WIDTH-1:0] rd1;
    logic [`MC_WIDTH-1:0] rd2;
    logic [`MC_WIDTH-1:0] rd3;

    core_control core_control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .dec_en      (dec_en),
        .half_sel    (half_sel),
        .word        (word),
        .op          (op),
        .rf_we       (rf_we),
        .flags_we    (flags_we),
        .wb          (wb),
        .mem_req     (mem_req),
        .evt         (evt),
        .result      (result),
        .rd1         (rd1),
        .rd2         (rd2),
        .rd3         (rd3)
    );

    instr_decoder instr_decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (dec_en),
        .instr    (word),
        .half_sel (half_sel),
        .flags    (flags),
        .op       (op)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .rd1        (rd1),
        .rd2        (rd2),
        .core_index (core_index),
        .flags_we   (flags_we),
        .flags      (flags),
        .result     (result)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (op.op1),
        .ra2   (op.op2),
        .ra3   (op.stack_param_reg),
        .rd1   (rd1),
        .rd2   (rd2),
        .rd3   (rd3),
        .we    (rf_we),
        .wa    (op.op1),
        .wd    (result)
    );

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "mini_core_config.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`MC_REGS_CODING-1:0] ra1,
    input  logic [`MC_REGS_CODING-1:0] ra2,
    input  logic [`MC_REGS_CODING-1:0] ra3,   // stack parameter source
    output logic [`MC_WIDTH-1:0]       rd1,
    output logic [`MC_WIDTH-1:0]       rd2,
    output logic [`MC_WIDTH-1:0]       rd3,
    input  logic                       we,
    input  logic [`MC_REGS_CODING-1:0] wa,
    input  logic [`MC_WIDTH-1:0]       wd
);

    localparam int NREGS = 1 << `MC_REGS_CODING;

    logic [`MC_WIDTH-1:0] regs [NREGS];

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign rd3 = regs[ra3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps
`include "mini_core_config.svh"

module exec_unit
    import mini_core_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  decoded_op_t                op,
    input  logic [`MC_WIDTH-1:0]       rd1,
    input  logic [`MC_WIDTH-1:0]       rd2,
    input  logic [`MC_CORE_NUMBER-1:0] core_index,
    input  logic                       flags_we,
    output logic [`MC_FLAGS-1:0]       flags,
    output logic [`MC_WIDTH-1:0]       result
);

    localparam int MSB = `MC_WIDTH - 1;

    logic [`MC_WIDTH:0]   sum;        // top bit is carry / borrow
    logic [`MC_WIDTH-1:0] alu_res;
    logic [`MC_FLAGS-1:0] flags_nxt;
    logic                 arith;

    always_comb begin
        sum     = '0;
        alu_res = '0;
        arith   = 1'b0;
        case (op.alu_opcode)
            ALU_ADD: begin
                sum   = {1'b0, rd1} + {1'b0, rd2};
                arith = 1'b1;
            end
            ALU_SUB, ALU_CMP: begin
                sum   = {1'b0, rd1} - {1'b0, rd2};
                arith = 1'b1;
            end
            ALU_AND: alu_res = rd1 & rd2;
            ALU_OR:  alu_res = rd1 | rd2;
            ALU_XOR: alu_res = rd1 ^ rd2;
            ALU_SHL: alu_res = rd1 << rd2[$clog2(`MC_WIDTH)-1:0];
            ALU_SHR: alu_res = rd1 >> rd2[$clog2(`MC_WIDTH)-1:0];
            default: alu_res = '0;
        endcase
        if (arith) alu_res = sum[MSB:0];

        flags_nxt              = '0;
        flags_nxt[`MC_ZERO]    = (alu_res == '0);
        flags_nxt[`MC_SIGN]    = alu_res[MSB];
        if (arith) begin
            flags_nxt[`MC_CARRY]    = sum[`MC_WIDTH];
            flags_nxt[`MC_OVERFLOW] = (op.alu_opcode == ALU_ADD) ?
                ((rd1[MSB] == rd2[MSB]) && (alu_res[MSB] != rd1[MSB])) :
                ((rd1[MSB] != rd2[MSB]) && (alu_res[MSB] != rd1[MSB]));
        end
    end

    always_comb begin
        result = '0;
        if (op.alu_en) begin
            result = alu_res;
        end else if (op.move_en) begin
            case (op.mov_kind)
                MOV_REG:   result = rd2;
                MOV_LOW:   result = {rd1[MSB:`MC_WIDTH/2], op.immediate};
                MOV_HIGH:  result = {op.immediate, rd1[`MC_WIDTH/2-1:0]};
                MOV_FLAGS: result = {{(`MC_WIDTH-`MC_FLAGS){1'b0}}, flags};
                MOV_CORE:  result = {{(`MC_WIDTH-`MC_CORE_NUMBER){1'b0}}, core_index};
                default:   result = rd1;   // jump target
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flags_we) begin
            flags <= flags_nxt;
        end
    end

endmodule

//--- hdl/core_control.sv
`timescale 1ns/1ps
`include "mini_core_config.svh"

module core_control
    import mini_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  instr_word_u          instr,
    output logic                 busy,
    output logic                 dec_en,
    output logic                 half_sel,
    output instr_word_u          word,
    input  decoded_op_t          op,
    output logic                 rf_we,
    output logic                 flags_we,
    output wb_t                  wb,
    output mem_req_t             mem_req,
    output side_evt_t            evt,
    input  logic [`MC_WIDTH-1:0] result,
    input  logic [`MC_WIDTH-1:0] rd1,
    input  logic [`MC_WIDTH-1:0] rd2,
    input  logic [`MC_WIDTH-1:0] rd3
);

    typedef enum logic [2:0] {S_IDLE, S_UPPER, S_BUBBLE, S_LOWER, S_COMMIT} state_e;

    state_e state;
    state_e state_nxt;
    logic   commit;
    logic   fire;

    assign dec_en   = (state == S_UPPER) || (state == S_LOWER);
    assign half_sel = (state == S_LOWER);
    // upper half commits during the bubble so the lower half sees its flags
    assign commit   = (state == S_BUBBLE) || (state == S_COMMIT);
    assign fire     = commit && op.suffix;
    assign rf_we    = fire && ((op.alu_en && op.alu_opcode != ALU_CMP) ||
                               (op.move_en && op.mov_kind != MOV_JUMP));
    assign flags_we = fire && op.alu_en;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (instr_valid) state_nxt = S_UPPER;
            S_UPPER:  state_nxt = word.long_i.is_long ? S_COMMIT : S_BUBBLE;
            S_BUBBLE: state_nxt = S_LOWER;
            S_LOWER:  state_nxt = S_COMMIT;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            busy  <= 1'b0;
        end else begin
            state <= state_nxt;
            busy  <= instr_valid || (state != S_IDLE);  // one extra cycle after commit
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word <= '0;
        end else if (state == S_IDLE && instr_valid) begin
            word <= instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb      <= '0;
            mem_req <= '0;
            evt     <= '0;
        end else begin
            wb      <= '0;
            mem_req <= '0;
            evt     <= '0;
            if (rf_we) begin
                wb.valid <= 1'b1;
                wb.idx   <= op.op1;
                wb.data  <= result;
            end
            if (fire && op.mem_en) begin
                mem_req.valid <= 1'b1;
                mem_req.we    <= op.wren;
                mem_req.addr  <= rd2;
                mem_req.wdata <= rd1;
            end
            if (fire && op.move_en && op.mov_kind == MOV_JUMP) begin
                evt.jump        <= 1'b1;
                evt.jump_target <= rd1;
            end
            if (fire && op.interrupt) begin
                evt.intr    <= 1'b1;
                evt.int_num <= op.int_num;
            end
            if (fire && op.write_stack_params) begin
                evt.stack_we     <= 1'b1;
                evt.stack_coding <= op.stack_param_coding;
                evt.stack_value  <= rd3;
            end
        end
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps
`include "mini_core_config.svh"

module instr_decoder
    import mini_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  instr_word_u          instr,
    input  logic                 half_sel,
    input  logic [`MC_FLAGS-1:0] flags,
    output decoded_op_t          op
);

    logic [`MC_WIDTH/2-1:0] short_i;
    logic                   main_cond;   // bits 9:6
    logic                   alt_cond;    // bits 8:5, stack / int / coreidx group
    logic [4:0]             sp_code;
    decoded_op_t            dec;

    function automatic logic cond_true(input logic [3:0] cond, input logic [`MC_FLAGS-1:0] f);
        logic z;
        logic s;
        logic v;
        logic c;
        z = f[`MC_ZERO];
        s = f[`MC_SIGN];
        v = f[`MC_OVERFLOW];
        c = f[`MC_CARRY];
        case (cond)
            4'b0000: return z;                  // eq
            4'b0001: return !z;                 // ne
            4'b0010: return !z && (s == v);     // gt
            4'b0011: return s != v;             // lt
            4'b0100: return s == v;             // ge
            4'b0101: return z || (s != v);      // le
            4'b0110: return c;
            4'b0111: return !c;
            4'b1000: return s;
            4'b1001: return !s;
            4'b1010: return 1'b1;               // al
            4'b1011: return 1'b0;               // nv
            4'b1100: return v;
            4'b1101: return !v;
            4'b1110: return c && !z;
            default: return !c || !z;
        endcase
    endfunction

    // jump opcode low bits to condition code
    function automatic logic [3:0] jump_cond(input logic [2:0] sel);
        case (sel)
            3'b001:  return 4'b0000;
            3'b010:  return 4'b0001;
            3'b011:  return 4'b0010;
            3'b100:  return 4'b0100;
            3'b101:  return 4'b0011;
            3'b110:  return 4'b0101;
            default: return 4'b1010;
        endcase
    endfunction

    always_comb begin
        dec       = '0;
        short_i   = half_sel ? instr.pair.lo : instr.pair.hi;
        main_cond = cond_true(short_i[9:6], flags);
        alt_cond  = cond_true(short_i[8:5], flags);
        sp_code   = short_i[13:9] - 5'b10010;

        if (instr.long_i.is_long) begin
            dec.move_en   = 1'b1;
            dec.mov_kind  = instr.long_i.movl ? MOV_LOW : MOV_HIGH;
            dec.op1       = instr.long_i.rd;
            dec.immediate = instr.long_i.imm;
            dec.suffix    = cond_true(instr.long_i.cond, flags);
        end else if (short_i[14]) begin
            dec.alu_en     = 1'b1;
            dec.alu_opcode = alu_op_e'(short_i[13:10]);
            dec.op1        = short_i[5:3];
            dec.op2        = short_i[2:0];
            dec.suffix     = main_cond;   // cmp keeps it, control drops the write-back
        end else if (short_i[13:11] == 3'b000) begin
            dec.mem_en = 1'b1;
            dec.wren   = short_i[10];
            dec.op1    = short_i[5:3];     // data
            dec.op2    = short_i[2:0];     // address
            dec.suffix = main_cond;
        end else if (short_i[13:10] == 4'b0010) begin
            dec.move_en  = 1'b1;
            dec.mov_kind = MOV_REG;
            dec.op1      = short_i[5:3];
            dec.op2      = short_i[2:0];
            dec.suffix   = main_cond;
        end else begin
            case (short_i[13:9])
                5'b01000: begin
                    dec.move_en  = 1'b1;
                    dec.mov_kind = MOV_FLAGS;
                    dec.op1      = short_i[8:6];
                    dec.suffix   = main_cond;
                end
                5'b01001, 5'b01010, 5'b01011, 5'b01100,
                5'b01101, 5'b01110, 5'b01111: begin
                    dec.move_en  = 1'b1;
                    dec.mov_kind = MOV_JUMP;
                    dec.op1      = short_i[8:6];
                    dec.suffix   = cond_true(jump_cond(short_i[11:9]), flags);
                end
                5'b10000: begin
                    dec.move_en  = 1'b1;
                    dec.mov_kind = MOV_CORE;
                    dec.op1      = short_i[4:2];
                    dec.suffix   = alt_cond;
                end
                5'b10001: begin
                    dec.interrupt = 1'b1;
                    dec.int_num   = short_i[4:2];
                    dec.suffix    = alt_cond;
                end
                5'b10010, 5'b10011, 5'b10100, 5'b10101: begin
                    dec.write_stack_params = 1'b1;
                    dec.stack_param_coding = sp_code[1:0];
                    dec.stack_param_reg    = short_i[4:2];
                    dec.suffix             = alt_cond;
                end
                default: dec = '0;        // unknown op does nothing
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op <= '0;
        end else if (en) begin
            op <= dec;
        end
    end

endmodule

//--- hdl/mini_core_pkg.sv
`include "mini_core_config.svh"

package mini_core_pkg;

    typedef logic [`MC_WIDTH-1:0]       word_t;
    typedef logic [`MC_REGS_CODING-1:0] reg_idx_t;

    // long form, movl / movh with 16-bit immediate
    typedef struct packed {
        logic                        is_long;
        logic [4:0]                  rsvd;
        logic                        movl;     // 1 movl, 0 movh
        logic [3:0]                  cond;
        reg_idx_t                    rd;
        logic [1:0]                  pad;
        logic [`MC_WIDTH/2-1:0]      imm;
    } long_instr_t;

    typedef struct packed {
        logic [`MC_WIDTH/2-1:0] hi;      // executed first
        logic [`MC_WIDTH/2-1:0] lo;
    } short_pair_t;

    typedef union packed {
        long_instr_t long_i;
        short_pair_t pair;
    } instr_word_u;

    typedef enum logic [`MC_OPCODE-1:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_XOR = 4'b0100,
        ALU_SHL = 4'b0101,
        ALU_SHR = 4'b0110,
        ALU_CMP = 4'b1100
    } alu_op_e;

    typedef enum logic [2:0] {
        MOV_REG   = 3'b000,
        MOV_LOW   = 3'b001,
        MOV_HIGH  = 3'b010,
        MOV_FLAGS = 3'b011,
        MOV_CORE  = 3'b100,
        MOV_JUMP  = 3'b111
    } mov_kind_e;

    typedef struct packed {
        logic                        alu_en;
        logic                        mem_en;
        logic                        move_en;
        logic                        wren;
        logic                        interrupt;
        logic                        write_stack_params;
        alu_op_e                     alu_opcode;
        mov_kind_e                   mov_kind;
        reg_idx_t                    op1;
        reg_idx_t                    op2;
        logic [`MC_WIDTH/2-1:0]      immediate;
        logic                        suffix;
        logic [`MC_INT_NUM-1:0]      int_num;
        logic [1:0]                  stack_param_coding; // msb / mse / sb / excl
        reg_idx_t                    stack_param_reg;
    } decoded_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   jump;
        word_t                  jump_target;
        logic                   intr;
        logic [`MC_INT_NUM-1:0] int_num;
        logic                   stack_we;
        logic [1:0]             stack_coding;
        word_t                  stack_value;
    } side_evt_t;

endpackage

//--- hdl/mini_core_config.svh
`ifndef MINI_CORE_CONFIG_SVH
`define MINI_CORE_CONFIG_SVH

// word and register file geometry
`define MC_WIDTH        32
`define MC_REGS_CODING  3

// alu opcode and flags
`define MC_OPCODE       4
`define MC_FLAGS        4

// flag bit positions
`define MC_CARRY        0
`define MC_SIGN         1
`define MC_OVERFLOW     2
`define MC_ZERO         3

`define MC_CORE_NUMBER  2   // core index width
`define MC_INT_NUM      3   // interrupt number width

`endif
